//--- apb_bus_pkg.sv
// APB bus definitions
// Transfer phase as seen by the protocol monitor, and APB4 protection width

package apb_bus_pkg;

  //////////////////////////////////////////////////////////////////////////////
  // Transfer phase
  //////////////////////////////////////////////////////////////////////////////

  // Monitor's view of the bus in the current cycle
  // IDLE   PSEL low
  // SETUP  first cycle of a transfer
  // ACCESS every later cycle, until PREADY ends it
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    SETUP  = 2'd1,
    ACCESS = 2'd2
  } phase_t;

  //////////////////////////////////////////////////////////////////////////////
  // APB4 signal widths
  //////////////////////////////////////////////////////////////////////////////

  // PPROT carries privileged, non-secure and instruction bits
  localparam int PROT_W = 3;

endpackage

//--- check_rule_pkg.sv
// Protocol rule definitions
// Rule numbering, rule vector and violation count width for the monitor

package check_rule_pkg;

  // Rule numbers, also the bit positions in a rule vector
  typedef enum logic [3:0] {
    RULE_PSEL_DROP       = 4'd0,
    RULE_PENABLE_SETUP   = 4'd1,
    RULE_PENABLE_ACCESS  = 4'd2,
    RULE_PADDR_UNSTABLE  = 4'd3,
    RULE_PWRITE_UNSTABLE = 4'd4,
    RULE_PSTRB_UNSTABLE  = 4'd5,
    RULE_PPROT_UNSTABLE  = 4'd6,
    RULE_PWDATA_UNSTABLE = 4'd7,
    RULE_PSTRB_READ      = 4'd8,
    RULE_PSTRB_PATTERN   = 4'd9,
    RULE_PADDR_UNALIGNED = 4'd10,
    RULE_WATCHDOG        = 4'd11
  } rule_e;

  localparam int NUM_RULES = 12;

  // One bit per rule
  typedef logic [NUM_RULES-1:0] rule_vec_t;

  // Violation count saturates at all ones
  localparam int COUNT_W = 16;

endpackage

//--- apb_phase_tracker.sv
// APB phase tracker
// Derives IDLE/SETUP/ACCESS from PSEL and past PREADY, checks the
// PSEL/PENABLE sequencing rules and runs the transfer watchdog

`timescale 1ns/1ps

module apb_phase_tracker #(
  parameter int WATCHDOG_TIMEOUT = 128
) (
  input  logic                      PCLK,
  input  logic                      PRESETn,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pready,
  output apb_bus_pkg::phase_t       phase,
  output check_rule_pkg::rule_vec_t phase_rules
);
  import apb_bus_pkg::*;
  import check_rule_pkg::*;

  // Last cycle's phase and PREADY
  phase_t prev_phase;
  logic   prev_pready;
  logic   wd_fire;

  // New transfer after idle or after a completed access
  always_comb
  begin
    if (!psel)
      phase = IDLE;
    else if (prev_phase == IDLE || (prev_phase == ACCESS && prev_pready))
      phase = SETUP;
    else
      phase = ACCESS;
  end

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      prev_phase  <= IDLE;
      prev_pready <= 1'b0;
    end
    else
    begin
      prev_phase  <= phase;
      prev_pready <= pready;
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // Sequencing rules
  //////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    phase_rules = '0;
    // PSEL dropped while the access was still waiting
    phase_rules[RULE_PSEL_DROP]      = !psel && prev_phase == ACCESS && !prev_pready;
    phase_rules[RULE_PENABLE_SETUP]  = phase == SETUP && penable;
    phase_rules[RULE_PENABLE_ACCESS] = phase == ACCESS && !penable;
    phase_rules[RULE_WATCHDOG]       = wd_fire;
  end

  //////////////////////////////////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////////////////////////////////

  generate
    if (WATCHDOG_TIMEOUT > 0)
    begin : g_watchdog
      localparam int WD_W = $clog2(WATCHDOG_TIMEOUT + 1);

      logic [WD_W-1:0] wd_cnt;
      logic            complete;

      assign complete = phase == ACCESS && penable && pready;

      // Reload outside a transfer and on completion, else count down and stop at zero
      always_ff @(posedge PCLK or negedge PRESETn)
      begin
        if (!PRESETn)
          wd_cnt <= WD_W'(WATCHDOG_TIMEOUT);
        else if (!psel || complete)
          wd_cnt <= WD_W'(WATCHDOG_TIMEOUT);
        else if (wd_cnt != '0)
          wd_cnt <= wd_cnt - 1'b1;
      end

      // Fires once, on the step into zero
      assign wd_fire = psel && !complete && wd_cnt == WD_W'(1);
    end
    else
    begin : g_no_watchdog
      assign wd_fire = 1'b0;
    end
  endgenerate

endmodule

//--- apb_stability_checker.sv
// APB request stability checker
// Keeps last cycle's request fields and flags any change during ACCESS

`timescale 1ns/1ps

module apb_stability_checker #(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32
) (
  input  logic                           PCLK,
  input  logic                           PRESETn,
  input  logic [ADDR_WIDTH-1:0]          paddr,
  input  logic                           pwrite,
  input  logic [DATA_WIDTH/8-1:0]        pstrb,
  input  logic [apb_bus_pkg::PROT_W-1:0] pprot,
  input  logic [DATA_WIDTH-1:0]          pwdata,
  input  apb_bus_pkg::phase_t            phase,
  output check_rule_pkg::rule_vec_t      stability_rules
);
  import apb_bus_pkg::*;
  import check_rule_pkg::*;

  localparam int STRB_W = DATA_WIDTH / 8;

  // Copies of the request from the previous cycle
  logic [ADDR_WIDTH-1:0] prev_paddr;
  logic                  prev_pwrite;
  logic [STRB_W-1:0]     prev_pstrb;
  logic [PROT_W-1:0]     prev_pprot;
  logic [DATA_WIDTH-1:0] prev_pwdata;
  logic                  in_access;

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      prev_paddr  <= '0;
      prev_pwrite <= 1'b0;
      prev_pstrb  <= '0;
      prev_pprot  <= '0;
      prev_pwdata <= '0;
    end
    else
    begin
      prev_paddr  <= paddr;
      prev_pwrite <= pwrite;
      prev_pstrb  <= pstrb;
      prev_pprot  <= pprot;
      prev_pwdata <= pwdata;
    end
  end

  // Previous cycle was part of the same transfer
  assign in_access = phase == ACCESS;

  always_comb
  begin
    stability_rules = '0;
    stability_rules[RULE_PADDR_UNSTABLE]  = in_access && paddr != prev_paddr;
    stability_rules[RULE_PWRITE_UNSTABLE] = in_access && pwrite != prev_pwrite;
    stability_rules[RULE_PSTRB_UNSTABLE]  = in_access && pstrb != prev_pstrb;
    stability_rules[RULE_PPROT_UNSTABLE]  = in_access && pprot != prev_pprot;
    // Write data only matters on writes
    stability_rules[RULE_PWDATA_UNSTABLE] = in_access && pwrite && pwdata != prev_pwdata;
  end

endmodule

//--- apb_strobe_checker.sv
// APB strobe and address checker
// Checks PSTRB on reads, PSTRB lane pattern on writes and PADDR alignment

`timescale 1ns/1ps

module apb_strobe_checker #(
  parameter int ADDR_WIDTH = 32,
  parameter int DATA_WIDTH = 32
) (
  input  logic                      psel,
  input  logic                      pwrite,
  input  logic [ADDR_WIDTH-1:0]     paddr,
  input  logic [DATA_WIDTH/8-1:0]   pstrb,
  output check_rule_pkg::rule_vec_t strobe_rules
);
  import check_rule_pkg::*;

  localparam int STRB_W    = DATA_WIDTH / 8;
  localparam int LANE_BITS = $clog2(STRB_W);

  // Byte offset bits inside one data word
  localparam logic [ADDR_WIDTH-1:0] LOW_MASK = ADDR_WIDTH'((64'd1 << LANE_BITS) - 1);

  // True when strb is exactly 2^k set lanes starting at a multiple of 2^k
  function automatic logic strobe_aligned(input logic [STRB_W-1:0] strb);
    logic [STRB_W-1:0] run;
    logic              ok;
    ok = 1'b0;
    for (int k = 0; k <= LANE_BITS; k++)
    begin
      for (int off = 0; off < STRB_W; off += (1 << k))
      begin
        // Lanes off .. off + 2^k - 1
        for (int b = 0; b < STRB_W; b++)
        begin
          run[b] = b >= off && b < off + (1 << k);
        end
        ok = ok | (strb == run);
      end
    end
    return ok;
  endfunction

  logic strb_any;
  logic pattern_ok;
  logic addr_low;

  assign strb_any   = |pstrb;
  assign pattern_ok = strobe_aligned(pstrb);
  assign addr_low   = |(paddr & LOW_MASK);

  //////////////////////////////////////////////////////////////////////////////
  // Rules, only while selected
  //////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    strobe_rules = '0;
    // Reads drive no strobes
    strobe_rules[RULE_PSTRB_READ]      = psel && !pwrite && strb_any;
    // Zero strobes on a write are legal
    strobe_rules[RULE_PSTRB_PATTERN]   = psel && pwrite && strb_any && !pattern_ok;
    strobe_rules[RULE_PADDR_UNALIGNED] = psel && addr_low;
  end

endmodule

//--- apb_violation_log.sv
// APB violation log
// Sticky per-rule status, violation pulse, saturating count and
// first failing rule since reset or clear

`timescale 1ns/1ps

module apb_violation_log (
  input  logic                                PCLK,
  input  logic                                PRESETn,
  input  logic                                clear,
  input  check_rule_pkg::rule_vec_t           phase_rules,
  input  check_rule_pkg::rule_vec_t           stability_rules,
  input  check_rule_pkg::rule_vec_t           strobe_rules,
  output check_rule_pkg::rule_vec_t           rule_status,
  output logic                                violation,
  output logic [check_rule_pkg::COUNT_W-1:0]  violation_count,
  output check_rule_pkg::rule_e               first_rule,
  output logic                                first_valid
);
  import check_rule_pkg::*;

  rule_vec_t merged;
  logic      any_rule;
  rule_e     lowest_rule;

  // Checkers own disjoint bits
  assign merged   = phase_rules | stability_rules | strobe_rules;
  assign any_rule = |merged;

  // Lowest-numbered rule set this cycle
  always_comb
  begin
    lowest_rule = RULE_PSEL_DROP;
    for (int i = NUM_RULES - 1; i >= 0; i--)
    begin
      if (merged[i])
        lowest_rule = rule_e'(i);
    end
  end

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      rule_status     <= '0;
      violation       <= 1'b0;
      violation_count <= '0;
      first_rule      <= RULE_PSEL_DROP;
      first_valid     <= 1'b0;
    end
    else if (clear)
    begin
      rule_status     <= '0;
      violation       <= 1'b0;
      violation_count <= '0;
      first_rule      <= RULE_PSEL_DROP;
      first_valid     <= 1'b0;
    end
    else
    begin
      rule_status <= rule_status | merged;
      violation   <= any_rule;
      // One per violating cycle, held at all ones
      if (any_rule && violation_count != '1)
        violation_count <= violation_count + 1'b1;
      if (any_rule && !first_valid)
      begin
        first_rule  <= lowest_rule;
        first_valid <= 1'b1;
      end
    end
  end

endmodule

//--- apb_protocol_monitor.sv
// APB4 protocol monitor
// Three rule checkers on one APB port feeding a common violation log

`timescale 1ns/1ps

module apb_protocol_monitor #(
  parameter int ADDR_WIDTH       = 32,
  parameter int DATA_WIDTH       = 32,
  parameter int WATCHDOG_TIMEOUT = 128
) (
  input  logic                               PCLK,
  input  logic                               PRESETn,
  input  logic                               PSEL,
  input  logic                               PENABLE,
  input  logic [ADDR_WIDTH-1:0]              PADDR,
  input  logic                               PWRITE,
  input  logic [DATA_WIDTH/8-1:0]            PSTRB,
  input  logic [apb_bus_pkg::PROT_W-1:0]     PPROT,
  input  logic [DATA_WIDTH-1:0]              PWDATA,
  input  logic                               PREADY,
  input  logic                               clear,
  output check_rule_pkg::rule_vec_t          rule_status,
  output logic                               violation,
  output logic [check_rule_pkg::COUNT_W-1:0] violation_count,
  output check_rule_pkg::rule_e              first_rule,
  output logic                               first_valid
);
  import apb_bus_pkg::*;
  import check_rule_pkg::*;

  phase_t    phase;
  rule_vec_t phase_rules;
  rule_vec_t stability_rules;
  rule_vec_t strobe_rules;

  // Phase, sequencing and watchdog
  apb_phase_tracker #(
    .WATCHDOG_TIMEOUT(WATCHDOG_TIMEOUT)
  ) u_phase (
    .PCLK       (PCLK),
    .PRESETn    (PRESETn),
    .psel       (PSEL),
    .penable    (PENABLE),
    .pready     (PREADY),
    .phase      (phase),
    .phase_rules(phase_rules)
  );

  apb_stability_checker #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) u_stability (
    .PCLK           (PCLK),
    .PRESETn        (PRESETn),
    .paddr          (PADDR),
    .pwrite         (PWRITE),
    .pstrb          (PSTRB),
    .pprot          (PPROT),
    .pwdata         (PWDATA),
    .phase          (phase),
    .stability_rules(stability_rules)
  );

  apb_strobe_checker #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) u_strobe (
    .psel        (PSEL),
    .pwrite      (PWRITE),
    .paddr       (PADDR),
    .pstrb       (PSTRB),
    .strobe_rules(strobe_rules)
  );

  // Record of everything the checkers report
  apb_violation_log u_log (
    .PCLK           (PCLK),
    .PRESETn        (PRESETn),
    .clear          (clear),
    .phase_rules    (phase_rules),
    .stability_rules(stability_rules),
    .strobe_rules   (strobe_rules),
    .rule_status    (rule_status),
    .violation      (violation),
    .violation_count(violation_count),
    .first_rule     (first_rule),
    .first_valid    (first_valid)
  );

endmodule

//--- tb_apb_protocol_monitor.sv
// APB protocol monitor testbench
// Drives legal and faulty APB4 transfers and checks the violation record
// against the rule vector each driven cycle should raise

`timescale 1ns/1ps

module tb_apb_protocol_monitor;
  import apb_bus_pkg::*;
  import check_rule_pkg::*;

  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int STRB_W    = DATA_W / 8;
  localparam int WD        = 16;
  localparam int NUM_LEGAL = 40;

  logic                PCLK;
  logic                PRESETn;
  logic                PSEL;
  logic                PENABLE;
  logic [ADDR_W-1:0]   PADDR;
  logic                PWRITE;
  logic [STRB_W-1:0]   PSTRB;
  logic [PROT_W-1:0]   PPROT;
  logic [DATA_W-1:0]   PWDATA;
  logic                PREADY;
  logic                clear;
  rule_vec_t           rule_status;
  logic                violation;
  logic [COUNT_W-1:0]  violation_count;
  rule_e               first_rule;
  logic                first_valid;

  // Rules the cycle on the bus should raise, driven with the bus
  rule_vec_t           cyc_rules;
  // Expected log state
  rule_vec_t           exp_status;
  logic                exp_violation;
  logic [COUNT_W-1:0]  exp_count;
  rule_e               exp_first;
  logic                exp_first_valid;
  logic                clear_d;

  integer              seed;
  int                  errors;
  int                  tests_run;
  int                  tests_failed;
  logic [STRB_W-1:0]   good_strb [8];

  apb_protocol_monitor #(
    .ADDR_WIDTH      (ADDR_W),
    .DATA_WIDTH      (DATA_W),
    .WATCHDOG_TIMEOUT(WD)
  ) UUT (
    .PCLK           (PCLK),
    .PRESETn        (PRESETn),
    .PSEL           (PSEL),
    .PENABLE        (PENABLE),
    .PADDR          (PADDR),
    .PWRITE         (PWRITE),
    .PSTRB          (PSTRB),
    .PPROT          (PPROT),
    .PWDATA         (PWDATA),
    .PREADY         (PREADY),
    .clear          (clear),
    .rule_status    (rule_status),
    .violation      (violation),
    .violation_count(violation_count),
    .first_rule     (first_rule),
    .first_valid    (first_valid)
  );

  always #2 PCLK = ~PCLK;

  //////////////////////////////////////////////////////////////////////////////
  // Expected record
  //////////////////////////////////////////////////////////////////////////////

  // Search from rule 0 upward
  function automatic rule_e lowest_rule(input rule_vec_t v);
    rule_e r;
    int    i;
    r = RULE_PSEL_DROP;
    i = 0;
    while (i < NUM_RULES && !v[i])
      i++;
    if (i < NUM_RULES)
      r = rule_e'(i);
    return r;
  endfunction

  function automatic rule_vec_t rule_bit(input rule_e r);
    return rule_vec_t'(1) << r;
  endfunction

  // Tally of violating cycles, sticky bits and first rule since clear
  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      exp_status      <= '0;
      exp_violation   <= 1'b0;
      exp_count       <= '0;
      exp_first       <= RULE_PSEL_DROP;
      exp_first_valid <= 1'b0;
      clear_d         <= 1'b0;
    end
    else
    begin
      clear_d <= clear;
      if (clear)
      begin
        exp_status      <= '0;
        exp_violation   <= 1'b0;
        exp_count       <= '0;
        exp_first       <= RULE_PSEL_DROP;
        exp_first_valid <= 1'b0;
      end
      else
      begin
        exp_status    <= exp_status | cyc_rules;
        exp_violation <= |cyc_rules;
        if (|cyc_rules && exp_count != '1)
          exp_count <= exp_count + COUNT_W'(1);
        if (|cyc_rules && !exp_first_valid)
        begin
          exp_first       <= lowest_rule(cyc_rules);
          exp_first_valid <= 1'b1;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////////
  // Checks on every edge
  //////////////////////////////////////////////////////////////////////////////

  status_matches: assert property (@(posedge PCLK) disable iff (!PRESETn)
    rule_status == exp_status)
  else
  begin
    $display("MISMATCH at %0t ns: rule_status %h, expected %h", $time,
             $sampled(rule_status), $sampled(exp_status));
    errors++;
  end

  // Pulse one edge after the faulty cycle is sampled
  violation_matches: assert property (@(posedge PCLK) disable iff (!PRESETn)
    violation == exp_violation)
  else
  begin
    $display("MISMATCH at %0t ns: violation %b, expected %b", $time,
             $sampled(violation), $sampled(exp_violation));
    errors++;
  end

  count_matches: assert property (@(posedge PCLK) disable iff (!PRESETn)
    violation_count == exp_count)
  else
  begin
    $display("MISMATCH at %0t ns: violation_count %0d, expected %0d", $time,
             $sampled(violation_count), $sampled(exp_count));
    errors++;
  end

  first_matches: assert property (@(posedge PCLK) disable iff (!PRESETn)
    first_valid == exp_first_valid && (!exp_first_valid || first_rule == exp_first))
  else
  begin
    $display("MISMATCH at %0t ns: first rule %0d valid %b, expected %0d valid %b", $time,
             $sampled(first_rule), $sampled(first_valid), $sampled(exp_first),
             $sampled(exp_first_valid));
    errors++;
  end

  // Whole record reads zero right after a clear
  cleared_to_zero: assert property (@(posedge PCLK) disable iff (!PRESETn)
    !clear_d || (rule_status == '0 && !violation && violation_count == '0 &&
                 !first_valid && first_rule == RULE_PSEL_DROP))
  else
  begin
    $display("MISMATCH at %0t ns: log outputs not zero after clear", $time);
    errors++;
  end

  //////////////////////////////////////////////////////////////////////////////
  // Bus tasks
  //////////////////////////////////////////////////////////////////////////////

  // Caller assigns the bus right after this returns, on the same edge
  task automatic next_cycle(input rule_vec_t rules);
    @(posedge PCLK);
    cyc_rules <= rules;
  endtask

  task automatic bus_idle();
    next_cycle('0);
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
    PREADY  <= 1'b0;
  endtask

  // Setup, waits, completing access; rules hold for every cycle
  task automatic transfer(input logic [ADDR_W-1:0] addr, input logic wr,
                          input logic [STRB_W-1:0] strb, input logic [PROT_W-1:0] prot,
                          input logic [DATA_W-1:0] data, input int waits,
                          input rule_vec_t rules);
    next_cycle(rules);
    PSEL    <= 1'b1;
    PENABLE <= 1'b0;
    PREADY  <= 1'b0;
    PADDR   <= addr;
    PWRITE  <= wr;
    PSTRB   <= strb;
    PPROT   <= prot;
    PWDATA  <= data;
    for (int i = 0; i < waits; i++)
    begin
      // Transfer cycle WD is the one the watchdog counts down to
      next_cycle(rules | ((i == WD - 2) ? rule_bit(RULE_WATCHDOG) : '0));
      PENABLE <= 1'b1;
    end
    next_cycle(rules);
    PENABLE <= 1'b1;
    PREADY  <= 1'b1;
  endtask

  task automatic penable_in_setup();
    next_cycle(rule_bit(RULE_PENABLE_SETUP));
    PSEL    <= 1'b1;
    PENABLE <= 1'b1;
    PREADY  <= 1'b0;
    PADDR   <= 32'h0000_0040;
    PWRITE  <= 1'b0;
    PSTRB   <= '0;
    next_cycle('0);
    PREADY  <= 1'b1;
    bus_idle();
  endtask

  // Field 0 PADDR, 1 PWRITE, 2 PSTRB, 3 PPROT, else PWDATA
  task automatic unstable_access(input int field, input logic wr, input rule_vec_t rules);
    next_cycle('0);
    PSEL    <= 1'b1;
    PENABLE <= 1'b0;
    PREADY  <= 1'b0;
    PADDR   <= 32'h0000_0100;
    PWRITE  <= wr;
    PSTRB   <= wr ? 4'b1111 : 4'b0000;
    PPROT   <= 3'b010;
    PWDATA  <= 32'h1234_5678;
    next_cycle('0);
    PENABLE <= 1'b1;
    next_cycle(rules);
    case (field)
      0: PADDR <= 32'h0000_0104;
      1: PWRITE <= !wr;
      2: PSTRB <= 4'b0011;
      3: PPROT <= 3'b011;
      default: PWDATA <= 32'h8765_4321;
    endcase
    next_cycle('0);
    PREADY <= 1'b1;
    bus_idle();
  endtask

  task automatic pulse_clear();
    next_cycle('0);
    clear <= 1'b1;
    next_cycle('0);
    clear <= 1'b0;
    bus_idle();
    bus_idle();
  endtask

  // Idle the bus until the sticky bit shows up
  task automatic wait_for_rule(input rule_e r, input int limit);
    int n;
    n = 0;
    @(negedge PCLK);
    while (!rule_status[r] && n < limit)
    begin
      bus_idle();
      @(negedge PCLK);
      n++;
    end
    if (!rule_status[r])
    begin
      $display("Timeout: rule %s was not recorded within %0d cycles", r.name(), limit);
      errors++;
    end
  endtask

  task automatic compare_value(input string what, input int got, input int want);
    assert (got == want)
    else
    begin
      $display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before)
      $display("test %s: ok", name);
    else
    begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, errors - errors_before);
    end
  endtask

  //////////////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////////////

  initial
  begin
    logic [31:0]       r;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    int                mark;
    seed         = 32'h2c94;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    good_strb    = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                     4'b0011, 4'b1100, 4'b1111, 4'b0000};
    PCLK      = 1'b0;
    PRESETn   = 1'b0;
    PSEL      = 1'b0;
    PENABLE   = 1'b0;
    PADDR     = '0;
    PWRITE    = 1'b0;
    PSTRB     = '0;
    PPROT     = '0;
    PWDATA    = '0;
    PREADY    = 1'b0;
    clear     = 1'b0;
    cyc_rules = '0;
    repeat (3) @(posedge PCLK);
    PRESETn <= 1'b1;
    bus_idle();

    // Random legal reads and writes, some back to back
    mark = errors;
    for (int n = 0; n < NUM_LEGAL; n++)
    begin
      r    = $random(seed);
      addr = $random(seed);
      data = $random(seed);
      addr[1:0] = 2'b00;
      transfer(addr, r[0], r[0] ? good_strb[r[5:3]] : '0, r[8:6], data, int'(r[2:1]), '0);
      if (!r[9])
        bus_idle();
    end
    bus_idle();
    pulse_clear();
    end_test("legal", mark);

    // PSEL and PENABLE sequencing
    mark = errors;
    penable_in_setup();
    wait_for_rule(RULE_PENABLE_SETUP, 4);
    pulse_clear();
    transfer(32'h0000_0080, 1'b0, '0, '0, '0, 0, '0);
    bus_idle();
    next_cycle('0);
    PSEL   <= 1'b1;
    PREADY <= 1'b0;
    next_cycle(rule_bit(RULE_PENABLE_ACCESS));
    next_cycle('0);
    PENABLE <= 1'b1;
    PREADY  <= 1'b1;
    bus_idle();
    wait_for_rule(RULE_PENABLE_ACCESS, 4);
    pulse_clear();
    next_cycle('0);
    PSEL <= 1'b1;
    next_cycle('0);
    PENABLE <= 1'b1;
    // Dropped while the access still waits
    next_cycle(rule_bit(RULE_PSEL_DROP));
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
    wait_for_rule(RULE_PSEL_DROP, 4);
    pulse_clear();
    end_test("sequencing", mark);

    // Request fields held during a waited access
    mark = errors;
    unstable_access(0, 1'b1, rule_bit(RULE_PADDR_UNSTABLE));
    pulse_clear();
    unstable_access(1, 1'b0, rule_bit(RULE_PWRITE_UNSTABLE));
    pulse_clear();
    unstable_access(2, 1'b1, rule_bit(RULE_PSTRB_UNSTABLE));
    pulse_clear();
    unstable_access(3, 1'b1, rule_bit(RULE_PPROT_UNSTABLE));
    pulse_clear();
    unstable_access(4, 1'b1, rule_bit(RULE_PWDATA_UNSTABLE));
    pulse_clear();
    unstable_access(4, 1'b0, '0);
    pulse_clear();
    end_test("stability", mark);

    // Strobes and address alignment
    mark = errors;
    transfer(32'h0000_0200, 1'b0, 4'b0001, '0, '0, 0, rule_bit(RULE_PSTRB_READ));
    bus_idle();
    pulse_clear();
    transfer(32'h0000_0204, 1'b1, 4'b0110, '0, 32'hA5A5_A5A5, 1, rule_bit(RULE_PSTRB_PATTERN));
    bus_idle();
    pulse_clear();
    transfer(32'h0000_0208, 1'b1, 4'b1100, '0, 32'h5A5A_5A5A, 1, '0);
    bus_idle();
    transfer(32'h0000_0201, 1'b0, '0, '0, '0, 0, rule_bit(RULE_PADDR_UNALIGNED));
    bus_idle();
    pulse_clear();
    transfer(32'h0000_0202, 1'b1, 4'b1111, '0, '0, 0, rule_bit(RULE_PADDR_UNALIGNED));
    bus_idle();
    pulse_clear();
    end_test("strobe_addr", mark);

    // Watchdog at WD cycles
    mark = errors;
    transfer(32'h0000_0300, 1'b1, 4'b1111, 3'b001, 32'h0BAD_F00D, 20, '0);
    bus_idle();
    wait_for_rule(RULE_WATCHDOG, 4);
    pulse_clear();
    transfer(32'h0000_0304, 1'b0, '0, 3'b001, '0, 14, '0);
    bus_idle();
    pulse_clear();
    end_test("watchdog", mark);

    // Count and first rule with two rules in one cycle
    mark = errors;
    transfer(32'h0000_0401, 1'b0, 4'b0010, '0, '0, 0,
             rule_bit(RULE_PSTRB_READ) | rule_bit(RULE_PADDR_UNALIGNED));
    bus_idle();
    penable_in_setup();
    wait_for_rule(RULE_PENABLE_SETUP, 4);
    compare_value("violation_count", int'(violation_count), 3);
    compare_value("first_rule", int'(first_rule), int'(RULE_PSTRB_READ));
    pulse_clear();
    end_test("log", mark);

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- flist.f
apb_bus_pkg.sv
check_rule_pkg.sv
apb_phase_tracker.sv
apb_stability_checker.sv
apb_strobe_checker.sv
apb_violation_log.sv
apb_protocol_monitor.sv
tb_apb_protocol_monitor.sv

//--- Makefile
# Verilator build and run for the APB protocol monitor

VERILATOR  ?= verilator
TOP        ?= tb_apb_protocol_monitor
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
PASS_MSG   ?= Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Status comes from the search for the pass line
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
